// File: source/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    // ==================================================
    // Sizes and sequencer constants
    // ==================================================
    localparam int word_width = 32;
    localparam int reg_index_width = 4;
    localparam int shift_amt_width = $clog2(word_width);
    localparam logic [reg_index_width-1:0] pc_reg = 4'd15;
    localparam int cycle_width = 8;
    localparam int flush_width = 3;
    localparam logic [flush_width-1:0] flush_after_reset = 3'd3;
    localparam logic [flush_width-1:0] flush_after_request = 3'd1;
    localparam int imm_width = 24;

    typedef logic [cycle_width-1:0] cycle_t;
    typedef logic [imm_width-1:0] imm_t;

    // ==================================================
    // Encodings
    // ==================================================
    typedef enum logic [2:0] {
        instr_dataproc_imm,
        instr_dataproc_reg_imm,
        instr_dataproc_reg_reg,
        instr_load,
        instr_store,
        instr_branch,
        instr_branch_link,
        instr_undefined
    } instr_type_t;

    typedef enum logic [1:0] {shift_lsl, shift_lsr, shift_asr, shift_ror} shift_t;

    // First sixteen follow the ARM opcode field
    typedef enum logic [4:0] {
        alu_and, alu_eor, alu_sub, alu_rsb,
        alu_add, alu_adc, alu_sbc, alu_rsc,
        alu_tst, alu_teq, alu_cmp, alu_cmn,
        alu_orr, alu_mov, alu_bic, alu_mvn,
        alu_sub_reversed
    } alu_op_t;

    typedef enum logic [1:0] {addr_src_pc, addr_src_incr, addr_src_alu} addr_src_t;
    typedef enum logic {a_src_reg_rn, a_src_imm} a_src_t;

    typedef enum logic [2:0] {
        b_src_imm,
        b_src_reg_rm,
        b_src_reg_rs,
        b_src_reg_rd,
        b_src_read_data
    } b_src_t;

    typedef enum logic [1:0] {wb_none, wb_rd, wb_rn} writeback_t;
    typedef enum logic [1:0] {phase_run, phase_hold_pc, phase_fetch, phase_refill} flush_phase_t;

    // ==================================================
    // Decoder output and control word
    // ==================================================
    typedef struct packed {
        instr_type_t instr_type;
        logic condition_pass;
        logic [reg_index_width-1:0] rn;
        logic [reg_index_width-1:0] rm;
        logic [reg_index_width-1:0] rd;
        logic [3:0] opcode;
        logic set_flags;
        shift_t shift_type;
        logic [shift_amt_width-1:0] shift_amount;
        // imm8 with rotate, imm12 or imm24 depending on the class
        logic [imm_width-1:0] imm;
        logic pre_index;
        logic up;
        logic byte_transfer;
        logic write_back;
        logic reg_offset;
    } decoded_word_t;

    typedef struct packed {
        logic pipeline_advance;
        logic fetch;
        logic incrementer_writeback;
        addr_src_t addr_src;
        a_src_t a_src;
        b_src_t b_src;
        logic [imm_width-1:0] b_imm;
        logic b_sign_extend;
        shift_t shift_type;
        logic [shift_amt_width-1:0] shift_amount;
        logic shift_latch_amt;
        logic shift_use_latch;
        logic shift_use_rrx;
        alu_op_t alu_op;
        writeback_t alu_writeback;
        logic alu_set_flags;
        logic alu_latch_op_b;
        logic alu_disable_op_b;
        logic alu_use_op_b_latch;
        logic pc_rn_add_4;
        logic pc_rm_add_4;
        logic mem_read_en;
        logic mem_write_en;
        logic mem_byte;
    } control_t;

    // Compare opcodes only update flags
    function automatic writeback_t dataproc_writeback(alu_op_t op);
        case (op)
            alu_tst, alu_teq, alu_cmp, alu_cmn: return wb_none;
            default: return wb_rd;
        endcase
    endfunction

endpackage

// File: source/cycle_sequencer.sv
`timescale 1ns/1ps

module cycle_sequencer (
    input  logic clk,
    input  logic reset,
    input  logic flush_req,
    input  logic advance,
    output logic [cpu_ctrl_pkg::cycle_width-1:0] cycle,
    output cpu_ctrl_pkg::flush_phase_t phase
);

    logic [cpu_ctrl_pkg::flush_width-1:0] flush_count;

    // Cycle within the current instruction
    always_ff @(posedge clk) begin
        if (reset) begin
            cycle <= '0;
        end else if (advance) begin
            cycle <= '0;
        end else begin
            cycle <= cycle + 1'b1;
        end
    end

    // Flush countdown starts full so the first instruction gets fetched
    always_ff @(posedge clk) begin
        if (reset) begin
            flush_count <= cpu_ctrl_pkg::flush_after_reset;
        end else if (flush_req) begin
            flush_count <= cpu_ctrl_pkg::flush_after_request;
        end else if (flush_count != '0) begin
            flush_count <= flush_count - 1'b1;
        end
    end

    // A request jumps straight into the fetch phase in its own cycle
    always_comb begin
        if (flush_count == cpu_ctrl_pkg::flush_after_reset) begin
            phase = cpu_ctrl_pkg::phase_hold_pc;
        end else if (flush_count == cpu_ctrl_pkg::flush_after_reset - 1'b1 || flush_req) begin
            phase = cpu_ctrl_pkg::phase_fetch;
        end else if (flush_count == cpu_ctrl_pkg::flush_after_request) begin
            phase = cpu_ctrl_pkg::phase_refill;
        end else begin
            phase = cpu_ctrl_pkg::phase_run;
        end
    end

endmodule

// File: source/dataproc_control.sv
`timescale 1ns/1ps

module dataproc_control (
    input  cpu_ctrl_pkg::decoded_word_t word,
    input  logic [cpu_ctrl_pkg::cycle_width-1:0] cycle,
    output cpu_ctrl_pkg::control_t control
);

    always_comb begin
        logic last_cycle;

        control = '0;
        last_cycle = 1'b0;

        case (word.instr_type)
            // ==================================================
            // Immediate operand as imm8 rotated right by 2*rot
            // ==================================================
            cpu_ctrl_pkg::instr_dataproc_imm: begin
                control.b_src = cpu_ctrl_pkg::b_src_imm;
                control.b_imm = cpu_ctrl_pkg::imm_t'(word.imm[7:0]);
                control.shift_type = cpu_ctrl_pkg::shift_ror;
                control.shift_amount = {word.imm[11:8], 1'b0};
                last_cycle = 1'b1;
            end

            // Rm shifted by an immediate amount
            cpu_ctrl_pkg::instr_dataproc_reg_imm: begin
                control.b_src = cpu_ctrl_pkg::b_src_reg_rm;
                control.shift_type = word.shift_type;
                control.shift_amount = word.shift_amount;
                // ROR #0 encodes RRX
                control.shift_use_rrx = (word.shift_type == cpu_ctrl_pkg::shift_ror) &&
                                        (word.shift_amount == '0);
                last_cycle = 1'b1;
            end

            // Rm shifted by Rs with the amount latched in an internal cycle first
            cpu_ctrl_pkg::instr_dataproc_reg_reg: begin
                if (cycle == '0) begin
                    control.b_src = cpu_ctrl_pkg::b_src_reg_rs;
                    control.shift_latch_amt = 1'b1;
                end else if (cycle == cpu_ctrl_pkg::cycle_t'(1)) begin
                    control.b_src = cpu_ctrl_pkg::b_src_reg_rm;
                    control.shift_type = word.shift_type;
                    control.shift_use_latch = 1'b1;
                    // PC reads one word further ahead after the extra cycle
                    control.pc_rn_add_4 = (word.rn == cpu_ctrl_pkg::pc_reg);
                    control.pc_rm_add_4 = (word.rm == cpu_ctrl_pkg::pc_reg);
                    last_cycle = 1'b1;
                end
            end

            default: ;
        endcase

        if (last_cycle) begin
            control.alu_op = cpu_ctrl_pkg::alu_op_t'({1'b0, word.opcode});
            control.alu_writeback = cpu_ctrl_pkg::dataproc_writeback(control.alu_op);
            control.alu_set_flags = word.set_flags;
            control.fetch = 1'b1;
            control.incrementer_writeback = 1'b1;
            control.addr_src = cpu_ctrl_pkg::addr_src_pc;
            control.pipeline_advance = 1'b1;
        end
    end

endmodule

// File: source/load_store_control.sv
`timescale 1ns/1ps

module load_store_control (
    input  cpu_ctrl_pkg::decoded_word_t word,
    input  logic [cpu_ctrl_pkg::cycle_width-1:0] cycle,
    output cpu_ctrl_pkg::control_t control
);

    logic is_load;
    logic base_writeback;
    cpu_ctrl_pkg::alu_op_t offset_op;

    assign is_load = (word.instr_type == cpu_ctrl_pkg::instr_load);
    // Post-indexing always updates the base
    assign base_writeback = !word.pre_index || word.write_back;
    assign offset_op = word.up ? cpu_ctrl_pkg::alu_add : cpu_ctrl_pkg::alu_sub;

    always_comb begin
        control = '0;

        if (cycle == '0) begin
            // ==================================================
            // Address calculation with prefetch
            // ==================================================
            control.fetch = 1'b1;
            control.incrementer_writeback = 1'b1;
            control.addr_src = cpu_ctrl_pkg::addr_src_alu;
            control.alu_op = offset_op;

            // Post-index puts the bare base on the bus and keeps the offset
            if (!word.pre_index) begin
                control.alu_disable_op_b = 1'b1;
                control.alu_latch_op_b = 1'b1;
            end else if (word.write_back) begin
                control.alu_latch_op_b = 1'b1;
            end

            if (!word.reg_offset) begin
                control.b_src = cpu_ctrl_pkg::b_src_imm;
                control.b_imm = cpu_ctrl_pkg::imm_t'(word.imm[11:0]);
                control.shift_type = cpu_ctrl_pkg::shift_lsl;
            end else begin
                control.b_src = cpu_ctrl_pkg::b_src_reg_rm;
                control.shift_type = word.shift_type;
                control.shift_amount = word.shift_amount;
                control.shift_use_rrx = (word.shift_type == cpu_ctrl_pkg::shift_ror) &&
                                        (word.shift_amount == '0);
            end
        end else if (cycle == cpu_ctrl_pkg::cycle_t'(1)) begin
            // ==================================================
            // Memory access and base update
            // ==================================================
            control.alu_op = offset_op;
            control.addr_src = cpu_ctrl_pkg::addr_src_pc;
            control.mem_byte = word.byte_transfer;
            if (base_writeback) begin
                control.alu_use_op_b_latch = 1'b1;
                control.alu_writeback = cpu_ctrl_pkg::wb_rn;
            end
            if (is_load) begin
                control.mem_read_en = 1'b1;
            end else begin
                control.b_src = cpu_ctrl_pkg::b_src_reg_rd;
                control.mem_write_en = 1'b1;
                control.pipeline_advance = 1'b1;
            end
        end else if (cycle == cpu_ctrl_pkg::cycle_t'(2) && is_load) begin
            // Read data passes through the ALU into Rd
            control.alu_op = cpu_ctrl_pkg::alu_mov;
            control.b_src = cpu_ctrl_pkg::b_src_read_data;
            control.alu_writeback = cpu_ctrl_pkg::wb_rd;
            control.mem_byte = word.byte_transfer;
            control.addr_src = cpu_ctrl_pkg::addr_src_pc;
            control.pipeline_advance = 1'b1;
        end
    end

endmodule

// File: source/branch_control.sv
`timescale 1ns/1ps

module branch_control (
    input  cpu_ctrl_pkg::decoded_word_t word,
    input  logic [cpu_ctrl_pkg::cycle_width-1:0] cycle,
    output cpu_ctrl_pkg::control_t control
);

    logic is_link;
    logic branch_cycle;

    assign is_link = (word.instr_type == cpu_ctrl_pkg::instr_branch_link);
    // BL spends its first cycle on the link register
    assign branch_cycle = is_link ? (cycle == cpu_ctrl_pkg::cycle_t'(1)) : (cycle == '0);

    always_comb begin
        control = '0;

        if (is_link && cycle == '0) begin
            // Return address is Rn - 4 since PC runs two words ahead
            control.a_src = cpu_ctrl_pkg::a_src_reg_rn;
            control.b_src = cpu_ctrl_pkg::b_src_imm;
            control.b_imm = cpu_ctrl_pkg::imm_t'(4);
            control.alu_op = cpu_ctrl_pkg::alu_sub;
            control.alu_writeback = cpu_ctrl_pkg::wb_rd;
        end

        if (branch_cycle) begin
            // Target = Rn + (sign_extend(imm24) << 2)
            control.a_src = cpu_ctrl_pkg::a_src_reg_rn;
            control.b_src = cpu_ctrl_pkg::b_src_imm;
            control.b_imm = word.imm;
            control.b_sign_extend = 1'b1;
            control.shift_type = cpu_ctrl_pkg::shift_lsl;
            control.shift_amount = 5'd2;
            control.alu_op = cpu_ctrl_pkg::alu_add;
            control.alu_writeback = cpu_ctrl_pkg::wb_rn;
            control.addr_src = cpu_ctrl_pkg::addr_src_alu;
            control.pipeline_advance = 1'b1;
        end
    end

endmodule

// File: source/control_unit.sv
`timescale 1ns/1ps

module control_unit (
    input  logic clk,
    input  logic reset,
    input  cpu_ctrl_pkg::decoded_word_t word,
    input  logic flush_req,
    output cpu_ctrl_pkg::control_t control
);

    logic [cpu_ctrl_pkg::cycle_width-1:0] cycle;
    cpu_ctrl_pkg::flush_phase_t phase;
    cpu_ctrl_pkg::control_t dataproc_word;
    cpu_ctrl_pkg::control_t load_store_word;
    cpu_ctrl_pkg::control_t branch_word;
    cpu_ctrl_pkg::control_t prefetch_word;

    cycle_sequencer sequencer (
        .clk       (clk),
        .reset     (reset),
        .flush_req (flush_req),
        .advance   (control.pipeline_advance),
        .cycle     (cycle),
        .phase     (phase)
    );

    dataproc_control dataproc (.word(word), .cycle(cycle), .control(dataproc_word));
    load_store_control load_store (.word(word), .cycle(cycle), .control(load_store_word));
    branch_control branch (.word(word), .cycle(cycle), .control(branch_word));

    // Fetch at PC and advance for refill and the skip path
    always_comb begin
        prefetch_word = '0;
        prefetch_word.fetch = 1'b1;
        prefetch_word.incrementer_writeback = 1'b1;
        prefetch_word.addr_src = cpu_ctrl_pkg::addr_src_pc;
        prefetch_word.pipeline_advance = 1'b1;
    end

    // ==================================================
    // Control word selection
    // ==================================================
    always_comb begin
        control = '0;
        case (phase)
            cpu_ctrl_pkg::phase_hold_pc: begin
                control.addr_src = cpu_ctrl_pkg::addr_src_pc;
            end
            cpu_ctrl_pkg::phase_fetch: begin
                control = prefetch_word;
                control.addr_src = cpu_ctrl_pkg::addr_src_incr;
                control.pipeline_advance = 1'b0;
            end
            cpu_ctrl_pkg::phase_refill: control = prefetch_word;
            default: begin
                if (!word.condition_pass) begin
                    control = prefetch_word;
                end else begin
                    case (word.instr_type)
                        cpu_ctrl_pkg::instr_dataproc_imm,
                        cpu_ctrl_pkg::instr_dataproc_reg_imm,
                        cpu_ctrl_pkg::instr_dataproc_reg_reg: control = dataproc_word;
                        cpu_ctrl_pkg::instr_load,
                        cpu_ctrl_pkg::instr_store: control = load_store_word;
                        cpu_ctrl_pkg::instr_branch,
                        cpu_ctrl_pkg::instr_branch_link: control = branch_word;
                        default: control = '0;
                    endcase
                end
            end
        endcase
    end

endmodule

// File: sim/control_checker.sv
`timescale 1ns/1ps

module control_checker (
    input  logic clk,
    input  logic reset,
    input  cpu_ctrl_pkg::decoded_word_t word,
    input  cpu_ctrl_pkg::control_t control,
    input  logic flushing,
    input  int exp_cycles,
    input  cpu_ctrl_pkg::addr_src_t exp_addr_src,
    input  cpu_ctrl_pkg::alu_op_t exp_alu_op,
    input  cpu_ctrl_pkg::writeback_t exp_writeback,
    input  logic exp_read,
    input  logic exp_write,
    output int error_count,
    output int check_count
);

    int errors = 0;
    int checks = 0;
    int cycle_count = 0;

    assign error_count = errors;
    assign check_count = checks;

    task automatic report_error(input string msg);
        errors++;
        $display("Error at %0d ns: %s", $time, msg);
    endtask

    // Cycles that end in an advance are compared against the expected final word
    task automatic check_final_cycle();
        if (cycle_count != exp_cycles) begin
            report_error($sformatf("advance after %0d cycles, expected %0d",
                                   cycle_count, exp_cycles));
        end
        if (control.addr_src != exp_addr_src) begin
            report_error($sformatf("addr_src %0d, expected %0d",
                                   control.addr_src, exp_addr_src));
        end
        if (control.alu_op != exp_alu_op) begin
            report_error($sformatf("alu_op %0d, expected %0d", control.alu_op, exp_alu_op));
        end
        if (control.alu_writeback != exp_writeback) begin
            report_error($sformatf("alu_writeback %0d, expected %0d",
                                   control.alu_writeback, exp_writeback));
        end
        if (control.mem_read_en != exp_read || control.mem_write_en != exp_write) begin
            report_error($sformatf("strobes read %0b write %0b, expected %0b %0b",
                                   control.mem_read_en, control.mem_write_en,
                                   exp_read, exp_write));
        end
        if (!flushing && word.condition_pass) begin
            if ((word.instr_type == cpu_ctrl_pkg::instr_branch ||
                 word.instr_type == cpu_ctrl_pkg::instr_branch_link) &&
                !control.b_sign_extend) begin
                report_error("branch without b_sign_extend");
            end
            // ROR #0 in the register-immediate form means RRX
            if (word.instr_type == cpu_ctrl_pkg::instr_dataproc_reg_imm &&
                control.shift_use_rrx != (word.shift_type == cpu_ctrl_pkg::shift_ror &&
                                          word.shift_amount == '0)) begin
                report_error("shift_use_rrx does not match the shift field");
            end
        end
    endtask

    // ==================================================
    // Sampling on the falling edge
    // ==================================================
    always @(negedge clk) begin
        if (reset) begin
            cycle_count = 0;
            if (control.pipeline_advance || control.fetch ||
                control.mem_read_en || control.mem_write_en) begin
                report_error("control word active during reset");
            end
        end else begin
            cycle_count++;
            if (flushing && (control.mem_read_en || control.mem_write_en)) begin
                report_error("memory strobe during a flush");
            end
            // Load memory cycle with base update when post-indexed or written back
            if (!flushing && word.condition_pass &&
                word.instr_type == cpu_ctrl_pkg::instr_load && cycle_count == 2) begin
                if (!control.mem_read_en) begin
                    report_error("load without mem_read_en in its second cycle");
                end
                if (control.alu_writeback != ((!word.pre_index || word.write_back) ?
                                              cpu_ctrl_pkg::wb_rn : cpu_ctrl_pkg::wb_none)) begin
                    report_error("load base writeback does not match the indexing bits");
                end
            end
            if (control.pipeline_advance) begin
                check_final_cycle();
                checks++;
                cycle_count = 0;
            end
        end
    end

endmodule

// File: sim/tb_control_unit.sv
`timescale 1ns/1ps

module tb_control_unit;

    localparam int advance_timeout = 50;
    localparam int field_count = 22;

    logic clk = 1'b0;
    logic reset;
    cpu_ctrl_pkg::decoded_word_t word;
    logic flush_req;
    cpu_ctrl_pkg::control_t control;

    // Expected results for the instruction on the bus
    logic flushing;
    int exp_cycles;
    cpu_ctrl_pkg::addr_src_t exp_addr_src;
    cpu_ctrl_pkg::alu_op_t exp_alu_op;
    cpu_ctrl_pkg::writeback_t exp_writeback;
    logic exp_read;
    logic exp_write;
    int error_count;
    int check_count;
    int fields[field_count];

    always #10 clk = ~clk;

    control_unit dut (
        .clk       (clk),
        .reset     (reset),
        .word      (word),
        .flush_req (flush_req),
        .control   (control)
    );

    control_checker control_checker (
        .clk           (clk),
        .reset         (reset),
        .word          (word),
        .control       (control),
        .flushing      (flushing),
        .exp_cycles    (exp_cycles),
        .exp_addr_src  (exp_addr_src),
        .exp_alu_op    (exp_alu_op),
        .exp_writeback (exp_writeback),
        .exp_read      (exp_read),
        .exp_write     (exp_write),
        .error_count   (error_count),
        .check_count   (check_count)
    );

    // Failed condition makes the DUT just prefetch and move on
    function automatic cpu_ctrl_pkg::decoded_word_t skip_word();
        cpu_ctrl_pkg::decoded_word_t w;
        w = '0;
        w.instr_type = cpu_ctrl_pkg::instr_undefined;
        return w;
    endfunction

    function automatic cpu_ctrl_pkg::decoded_word_t fields_to_word();
        cpu_ctrl_pkg::decoded_word_t w;
        w.instr_type = cpu_ctrl_pkg::instr_type_t'(fields[0][2:0]);
        w.condition_pass = fields[1][0];
        w.rn = fields[2][3:0];
        w.rm = fields[3][3:0];
        w.rd = fields[4][3:0];
        w.opcode = fields[5][3:0];
        w.set_flags = fields[6][0];
        w.shift_type = cpu_ctrl_pkg::shift_t'(fields[7][1:0]);
        w.shift_amount = fields[8][4:0];
        w.imm = fields[9][23:0];
        w.pre_index = fields[10][0];
        w.up = fields[11][0];
        w.byte_transfer = fields[12][0];
        w.write_back = fields[13][0];
        w.reg_offset = fields[14][0];
        return w;
    endfunction

    task automatic wait_for_advance(output logic seen);
        int waited;
        seen = 1'b0;
        waited = 0;
        while (!seen && waited < advance_timeout) begin
            @(negedge clk);
            seen = control.pipeline_advance;
            waited++;
        end
    endtask

    // One instruction with its expected final cycle held until it retires
    task automatic issue(input cpu_ctrl_pkg::decoded_word_t w, input logic flush,
                         input int cycles, input int addr, input int op, input int wb,
                         input int rd_en, input int wr_en, output logic seen);
        @(posedge clk);
        word <= w;
        flush_req <= flush;
        flushing <= flush;
        exp_cycles <= cycles;
        exp_addr_src <= cpu_ctrl_pkg::addr_src_t'(addr[1:0]);
        exp_alu_op <= cpu_ctrl_pkg::alu_op_t'(op[4:0]);
        exp_writeback <= cpu_ctrl_pkg::writeback_t'(wb[1:0]);
        exp_read <= rd_en[0];
        exp_write <= wr_en[0];
        if (flush) begin
            @(posedge clk);
            flush_req <= 1'b0;
        end
        wait_for_advance(seen);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin : main
        int fd;
        int count;
        int idle;
        int line_no;
        logic seen;
        logic failed;
        string line;

        reset = 1'b1;
        word = skip_word();
        flush_req = 1'b0;
        // Reset flush sequence where refill advances in the third cycle at PC
        flushing = 1'b1;
        exp_cycles = 3;
        exp_addr_src = cpu_ctrl_pkg::addr_src_pc;
        exp_alu_op = cpu_ctrl_pkg::alu_and;
        exp_writeback = cpu_ctrl_pkg::wb_none;
        exp_read = 1'b0;
        exp_write = 1'b0;
        failed = 1'b0;
        line_no = 0;
        fd = 0;
        void'($urandom(32'h698a2d7d));

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        wait_for_advance(seen);
        if (!seen) begin
            $display("Timeout: no pipeline_advance after reset");
            failed = 1'b1;
        end

        if (!failed) begin
            fd = $fopen("sim/control_input.txt", "r");
            if (fd == 0) begin
                $display("Could not open sim/control_input.txt");
                failed = 1'b1;
            end
        end

        while (!failed && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                            fields[0], fields[1], fields[2], fields[3], fields[4], fields[5],
                            fields[6], fields[7], fields[8], fields[9], fields[10], fields[11],
                            fields[12], fields[13], fields[14], fields[15], fields[16],
                            fields[17], fields[18], fields[19], fields[20], fields[21]);
            // Comment and blank lines do not parse
            if (count == field_count) begin
                line_no++;
                issue(fields_to_word(), fields[15][0], fields[16], fields[17], fields[18],
                      fields[19], fields[20], fields[21], seen);
                if (!seen) begin
                    $display("Timeout: no pipeline_advance for stimulus line %0d", line_no);
                    failed = 1'b1;
                end
                idle = $urandom % 3;
                for (int i = 0; i < idle && !failed; i++) begin
                    issue(skip_word(), 1'b0, 1, 0, 0, 0, 0, 0, seen);
                    if (!seen) begin
                        $display("Timeout: idle cycle did not advance after line %0d", line_no);
                        failed = 1'b1;
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        @(posedge clk);
        $display("Lines: %0d  checks: %0d  errors: %0d", line_no, check_count, error_count);
        if (!failed && error_count == 0 && line_no > 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: build.f
source/cpu_ctrl_pkg.sv
source/cycle_sequencer.sv
source/dataproc_control.sv
source/load_store_control.sv
source/branch_control.sv
source/control_unit.sv
sim/control_checker.sv
sim/tb_control_unit.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_control_unit -f build.f -o tb_control_unit
./obj_dir/tb_control_unit > sim.log 2>&1
cat sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: sim/control_input.txt
# type cond rn rm rd op s sh amt imm pre up byte wb roff | flush cycles addr alu_op alu_wb rd wr
# types 0..7 = dp_imm dp_reg_imm dp_reg_reg load store branch branch_link undefined
0 1 1 0 2 4 0 0 00 0000ff 0 0 0 0 0 0 1 0 04 1 0 0
0 1 3 0 0 a 1 0 00 000204 0 0 0 0 0 0 1 0 0a 0 0 0
1 1 0 5 6 d 0 3 00 000000 0 0 0 0 0 0 1 0 0d 1 0 0
1 1 2 3 0 8 1 0 04 000000 0 0 0 0 0 0 1 0 08 0 0 0
2 1 f 4 7 2 0 1 00 000000 0 0 0 0 0 0 2 0 02 1 0 0
2 1 1 f 0 9 1 2 00 000000 0 0 0 0 0 0 2 0 09 0 0 0
3 1 2 0 3 0 0 0 00 000010 1 1 0 0 0 0 3 0 0d 1 0 0
3 1 2 0 3 0 0 0 00 000008 0 0 0 0 0 0 3 0 0d 1 0 0
3 1 4 2 5 0 0 0 02 000000 1 1 1 1 1 0 3 0 0d 1 0 0
4 1 2 0 3 0 0 0 00 000004 1 1 0 0 0 0 2 0 04 0 0 1
4 1 2 0 3 0 0 0 00 00000c 0 0 0 0 0 0 2 0 02 2 0 1
4 1 6 1 3 0 0 3 00 000000 1 1 1 1 1 0 2 0 04 2 0 1
5 1 f 0 0 0 0 0 00 fffffe 0 0 0 0 0 0 1 2 04 2 0 0
6 1 f 0 e 0 0 0 00 000040 0 0 0 0 0 0 2 2 04 2 0 0
0 0 1 0 2 4 0 0 00 000001 0 0 0 0 0 0 1 0 00 0 0 0
3 0 2 0 3 0 0 0 00 000010 1 1 0 0 0 0 1 0 00 0 0 0
3 1 2 0 3 0 0 0 00 000010 1 1 0 0 0 1 2 0 00 0 0 0
4 1 2 0 3 0 0 0 00 000004 0 0 0 0 0 1 2 0 00 0 0 0
2 1 1 2 3 4 0 0 00 000000 0 0 0 0 0 1 2 0 00 0 0 0
0 1 1 0 2 c 1 0 00 000f0f 0 0 0 0 0 0 1 0 0c 1 0 0
6 1 f 0 e 0 0 0 00 ff8000 0 0 0 0 0 0 2 2 04 2 0 0
1 1 0 f 2 1 0 2 1f 000000 0 0 0 0 0 0 1 0 01 1 0 0
